/* Bender.yml */
package:
  name: accbus_cpu

sources:
  - source/cpuPkg.sv
  - source/sequenceCounter.sv
  - source/controlLogic.sv
  - source/aluUnit.sv
  - source/dataPath.sv
  - source/mainMemory.sv
  - source/cpuTop.sv
  - target: test
    files:
      - tests/cpuTop_sva.sv
      - tests/cpuTb.sv

/* source/aluUnit.sv */
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluOp_t               aluSel,
    output logic [dataWidth-1:0] result,
    output logic                 n,
    output logic                 z,
    output logic                 c,
    output logic                 v
);

    localparam int msb = dataWidth - 1;

    logic [dataWidth:0] sum;

    always_comb begin
        sum = '0;
        result = '0;
        c = 1'b0;
        v = 1'b0;
        case (aluSel)
            aluAdd: begin
                sum = {1'b0, a} + {1'b0, b};
                result = sum[msb:0];
                c = sum[dataWidth];
                v = (a[msb] == b[msb]) && (result[msb] != a[msb]);
            end
            // a + ~b + 1, carry out set means no borrow
            aluSub: begin
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                result = sum[msb:0];
                c = sum[dataWidth];
                v = (a[msb] != b[msb]) && (result[msb] != a[msb]);
            end
            // low half of the product
            aluMul: result = a * b;
            aluLsr: result = a >> b[3:0];
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluMvn: result = ~b;
            default: result = '0;
        endcase
    end

    assign n = result[msb];
    assign z = (result == '0);

endmodule

`default_nettype wire

/* source/controlLogic.sv */
`default_nettype none

module controlLogic import cpuPkg::*; (
    input  logic [stateCount-1:0] cpuState,
    input  logic                  n,
    input  logic                  z,
    // carry is not consulted by any branch condition
    input  logic                  c,
    input  logic                  v,
    output logic                  rselLoad,
    output logic                  rop1Load,
    output logic                  rop2Load,
    output logic                  trLoad,
    output logic                  arLoad,
    output logic                  pcLoad,
    output logic                  drLoad,
    output logic                  acLoad,
    output logic                  irLoad,
    output logic                  gprLoad,
    output logic                  memLoad,
    output logic                  pcInc,
    output logic                  counterLd,
    output logic                  counterInc,
    output logic                  counterClr,
    output aluOp_t                aluSel,
    output busSrc_t               busSel
);

    // encoded copy of the one-hot state, handy in waveforms
    cpuState_t stateName;

    always_comb begin
        stateName = nop1;
        for (int i = 0; i < stateCount; i++) begin
            if (cpuState[i]) begin
                stateName = cpuState_t'(i[5:0]);
            end
        end
    end

    always_comb begin
        rselLoad   = 1'b0;
        rop1Load   = 1'b0;
        rop2Load   = 1'b0;
        trLoad     = 1'b0;
        arLoad     = 1'b0;
        pcLoad     = 1'b0;
        drLoad     = 1'b0;
        acLoad     = 1'b0;
        irLoad     = 1'b0;
        gprLoad    = 1'b0;
        memLoad    = 1'b0;
        pcInc      = 1'b0;
        counterLd  = 1'b0;
        counterInc = 1'b0;
        counterClr = 1'b0;
        busSel     = busPc;
        case (stateName)
            fetch1: begin
                arLoad = 1'b1;
                counterInc = 1'b1;
            end
            fetch2: begin
                busSel = busMem;
                drLoad = 1'b1;
                pcInc = 1'b1;
                counterInc = 1'b1;
            end
            // decode fields straight off the instruction word in DR
            fetch3: begin
                busSel = busDr;
                irLoad = 1'b1;
                rselLoad = 1'b1;
                rop1Load = 1'b1;
                rop2Load = 1'b1;
                counterLd = 1'b1;
            end
            mov1: begin
                busSel = busRop2;
                gprLoad = 1'b1;
                counterClr = 1'b1;
            end
            altMov1: begin
                busSel = busRop1;
                trLoad = 1'b1;
                counterInc = 1'b1;
            end
            altMov2: begin
                busSel = busTr;
                gprLoad = 1'b1;
                counterClr = 1'b1;
            end
            // address from immediate or from source register
            ldr1, str1: begin
                busSel = busRop2;
                arLoad = 1'b1;
                counterInc = 1'b1;
            end
            altLdr1, altStr1: begin
                busSel = busRop1;
                arLoad = 1'b1;
                counterInc = 1'b1;
            end
            ldr2, altLdr2: begin
                busSel = busMem;
                drLoad = 1'b1;
                counterInc = 1'b1;
            end
            ldr3, altLdr3: begin
                busSel = busDr;
                gprLoad = 1'b1;
                counterClr = 1'b1;
            end
            str2, altStr2: begin
                busSel = busGprRead;
                trLoad = 1'b1;
                counterInc = 1'b1;
            end
            str3, altStr3: begin
                busSel = busTr;
                drLoad = 1'b1;
                counterInc = 1'b1;
            end
            str4, altStr4: begin
                busSel = busDr;
                memLoad = 1'b1;
                counterClr = 1'b1;
            end
            // only the flags matter here
            cmp1: begin
                acLoad = 1'b1;
                counterClr = 1'b1;
            end
            b1, bgt1, blt1, beq1: begin
                busSel = busRop2;
                counterClr = 1'b1;
                case (stateName)
                    bgt1:    pcLoad = !z && (n == v);
                    blt1:    pcLoad = (n != v);
                    beq1:    pcLoad = z;
                    default: pcLoad = 1'b1;
                endcase
            end
            add1, sub1, mul1, lsr1, and1, or1, mvn1: begin
                acLoad = 1'b1;
                counterInc = 1'b1;
            end
            add2, sub2, mul2, lsr2, and2, or2, mvn2: begin
                busSel = busAc;
                gprLoad = 1'b1;
                counterClr = 1'b1;
            end
            // nop1 and spare codes go straight back to fetch1
            default: counterClr = 1'b1;
        endcase
    end

    always_comb begin
        case (stateName)
            sub1, cmp1: aluSel = aluSub;
            mul1:       aluSel = aluMul;
            lsr1:       aluSel = aluLsr;
            and1:       aluSel = aluAnd;
            or1:        aluSel = aluOr;
            mvn1:       aluSel = aluMvn;
            default:    aluSel = aluAdd;
        endcase
    end

endmodule

`default_nettype wire

/* source/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 16;
    localparam int gprCount = 4;
    // one-hot width, codes above mvn2 are spare and decode like nop
    localparam int stateCount = 43;

    typedef enum logic [3:0] {
        opNop, opMov, opLdr, opStr, opCmp, opB, opBgt, opBlt,
        opBeq, opAdd, opSub, opMul, opLsr, opAnd, opOr, opMvn
    } opcode_t;

    // * marks the first execute state of a routine
    typedef enum logic [5:0] {
        fetch1 = 6'd0, fetch2, fetch3,
        nop1,                              // *
        mov1, altMov1, altMov2,            // * *
        ldr1, ldr2, ldr3,                  // *
        altLdr1, altLdr2, altLdr3,         // *
        str1, str2, str3, str4,            // *
        altStr1, altStr2, altStr3, altStr4, // *
        cmp1, b1, bgt1, blt1, beq1,        // all *
        add1, add2, sub1, sub2,
        mul1, mul2, lsr1, lsr2,
        and1, and2, or1, or2,
        mvn1, mvn2
    } cpuState_t;

    // system bus sources
    typedef enum logic [3:0] {
        busPc      = 4'd0,
        busDr      = 4'd1,
        busAr      = 4'd2,
        busAc      = 4'd3,
        busMem     = 4'd4,
        busTr      = 4'd5,
        busRop1    = 4'd6,
        busRop2    = 4'd7,
        busGprRead = 4'd8
    } busSrc_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluMul, aluLsr, aluAnd, aluOr, aluMvn
    } aluOp_t;

endpackage

`default_nettype wire

/* source/cpuTop.sv */
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter int memAddrWidth = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    progWe,
    input  logic [memAddrWidth-1:0] progAddr,
    input  logic [dataWidth-1:0]    progData,
    output logic                    storeValid,
    output logic [memAddrWidth-1:0] storeAddr,
    output logic [dataWidth-1:0]    storeData
);

    logic [stateCount-1:0] cpuState;
    logic rselLoad, rop1Load, rop2Load, trLoad, arLoad, pcLoad;
    logic drLoad, acLoad, irLoad, gprLoad, memLoad, pcInc;
    logic counterLd, counterInc, counterClr;
    aluOp_t aluSel;
    busSrc_t busSel;
    opcode_t opcode;
    logic alt;
    logic n, z, c, v;
    logic aluN, aluZ, aluC, aluV;
    logic [dataWidth-1:0] aluA, aluB, aluResult, busData, memRdData;
    logic [memAddrWidth-1:0] arValue;

    sequenceCounter seq0 (
        .clk(clk), .rst(rst), .counterLd(counterLd), .counterInc(counterInc),
        .counterClr(counterClr), .opcode(opcode), .alt(alt), .cpuState(cpuState)
    );

    controlLogic ctrl0 (
        .cpuState(cpuState), .n(n), .z(z), .c(c), .v(v),
        .rselLoad(rselLoad), .rop1Load(rop1Load), .rop2Load(rop2Load), .trLoad(trLoad),
        .arLoad(arLoad), .pcLoad(pcLoad), .drLoad(drLoad), .acLoad(acLoad),
        .irLoad(irLoad), .gprLoad(gprLoad), .memLoad(memLoad), .pcInc(pcInc),
        .counterLd(counterLd), .counterInc(counterInc), .counterClr(counterClr),
        .aluSel(aluSel), .busSel(busSel)
    );

    dataPath #(.memAddrWidth(memAddrWidth)) path0 (
        .clk(clk), .rst(rst), .rselLoad(rselLoad), .rop1Load(rop1Load),
        .rop2Load(rop2Load), .trLoad(trLoad), .arLoad(arLoad), .pcLoad(pcLoad),
        .drLoad(drLoad), .acLoad(acLoad), .irLoad(irLoad), .gprLoad(gprLoad),
        .pcInc(pcInc), .busSel(busSel), .aluResult(aluResult), .aluN(aluN),
        .aluZ(aluZ), .aluC(aluC), .aluV(aluV), .memRdData(memRdData),
        .aluA(aluA), .aluB(aluB), .busData(busData), .arValue(arValue),
        .opcode(opcode), .alt(alt), .n(n), .z(z), .c(c), .v(v)
    );

    aluUnit alu0 (
        .a(aluA), .b(aluB), .aluSel(aluSel), .result(aluResult),
        .n(aluN), .z(aluZ), .c(aluC), .v(aluV)
    );

    mainMemory #(.memAddrWidth(memAddrWidth)) mem0 (
        .clk(clk), .addr(arValue), .wrData(busData), .wrEn(memLoad),
        .progWe(progWe), .progAddr(progAddr), .progData(progData), .rdData(memRdData)
    );

    // every memory write is a visible store
    assign storeValid = memLoad;
    assign storeAddr = arValue;
    assign storeData = busData;

endmodule

`default_nettype wire

/* source/dataPath.sv */
`default_nettype none

module dataPath import cpuPkg::*; #(
    parameter int memAddrWidth = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rselLoad,
    input  logic                    rop1Load,
    input  logic                    rop2Load,
    input  logic                    trLoad,
    input  logic                    arLoad,
    input  logic                    pcLoad,
    input  logic                    drLoad,
    input  logic                    acLoad,
    input  logic                    irLoad,
    input  logic                    gprLoad,
    input  logic                    pcInc,
    input  busSrc_t                 busSel,
    input  logic [dataWidth-1:0]    aluResult,
    input  logic                    aluN,
    input  logic                    aluZ,
    input  logic                    aluC,
    input  logic                    aluV,
    input  logic [dataWidth-1:0]    memRdData,
    output logic [dataWidth-1:0]    aluA,
    output logic [dataWidth-1:0]    aluB,
    output logic [dataWidth-1:0]    busData,
    output logic [memAddrWidth-1:0] arValue,
    output opcode_t                 opcode,
    output logic                    alt,
    output logic                    n,
    output logic                    z,
    output logic                    c,
    output logic                    v
);

    logic [dataWidth-1:0] pc, dr, tr, ac, ir, rop1, rop2;
    logic [memAddrWidth-1:0] ar;
    logic [$clog2(gprCount)-1:0] rsel;
    logic [dataWidth-1:0] gpr [gprCount];
    logic [dataWidth-1:0] decodeWord;

    // system bus
    always_comb begin
        busData = '0;
        case (busSel)
            busPc:      busData = pc;
            busDr:      busData = dr;
            busAr:      busData[memAddrWidth-1:0] = ar;
            busAc:      busData = ac;
            busMem:     busData = memRdData;
            busTr:      busData = tr;
            busRop1:    busData = rop1;
            busRop2:    busData = rop2;
            busGprRead: busData = gpr[rsel];
            default:    busData = '0;
        endcase
    end

    // opcode bypass so the counter can load its start state in fetch3
    assign decodeWord = irLoad ? busData : ir;
    assign opcode = opcode_t'(decodeWord[15:12]);
    assign alt = decodeWord[11];

    assign aluA = gpr[rsel];
    assign aluB = ir[11] ? rop1 : rop2;
    assign arValue = ar;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= busData;
        end else if (pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (arLoad) ar <= busData[memAddrWidth-1:0];
        if (drLoad) dr <= busData;
        if (trLoad) tr <= busData;
        if (acLoad) ac <= aluResult;
        if (irLoad) ir <= busData;
        if (rselLoad) rsel <= busData[10:9];
        // source register value and zero-extended immediate
        if (rop1Load) rop1 <= gpr[busData[7:6]];
        if (rop2Load) rop2 <= dataWidth'(busData[7:0]);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < gprCount; i++) begin
                gpr[i] <= '0;
            end
        end else if (gprLoad) begin
            gpr[rsel] <= busData;
        end
    end

    // NZCV follow every AC load
    always_ff @(posedge clk) begin
        if (rst) begin
            {n, z, c, v} <= 4'b0000;
        end else if (acLoad) begin
            {n, z, c, v} <= {aluN, aluZ, aluC, aluV};
        end
    end

endmodule

`default_nettype wire

/* source/mainMemory.sv */
`default_nettype none

module mainMemory import cpuPkg::*; #(
    parameter int memAddrWidth = 8
) (
    input  logic                    clk,
    input  logic [memAddrWidth-1:0] addr,
    input  logic [dataWidth-1:0]    wrData,
    input  logic                    wrEn,
    input  logic                    progWe,
    input  logic [memAddrWidth-1:0] progAddr,
    input  logic [dataWidth-1:0]    progData,
    output logic [dataWidth-1:0]    rdData
);

    logic [dataWidth-1:0] mem [2**memAddrWidth];

    // program loading takes the write port first
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = mem[addr];

endmodule

`default_nettype wire

/* source/sequenceCounter.sv */
`default_nettype none

module sequenceCounter import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  counterLd,
    input  logic                  counterInc,
    input  logic                  counterClr,
    input  opcode_t               opcode,
    input  logic                  alt,
    output logic [stateCount-1:0] cpuState
);

    cpuState_t stateIdx;
    cpuState_t startState;

    // first execute state of each instruction
    always_comb begin
        case (opcode)
            opNop:   startState = nop1;
            opMov:   startState = alt ? altMov1 : mov1;
            opLdr:   startState = alt ? altLdr1 : ldr1;
            opStr:   startState = alt ? altStr1 : str1;
            opCmp:   startState = cmp1;
            opB:     startState = b1;
            opBgt:   startState = bgt1;
            opBlt:   startState = blt1;
            opBeq:   startState = beq1;
            opAdd:   startState = add1;
            opSub:   startState = sub1;
            opMul:   startState = mul1;
            opLsr:   startState = lsr1;
            opAnd:   startState = and1;
            opOr:    startState = or1;
            opMvn:   startState = mvn1;
            default: startState = nop1;
        endcase
    end

    // clear wins over load, load over increment
    always_ff @(posedge clk) begin
        if (rst) begin
            stateIdx <= fetch1;
        end else if (counterClr) begin
            stateIdx <= fetch1;
        end else if (counterLd) begin
            stateIdx <= startState;
        end else if (counterInc) begin
            stateIdx <= cpuState_t'(stateIdx + 6'd1);
        end
    end

    always_comb begin
        cpuState = '0;
        cpuState[stateIdx] = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/cpuTb.sv */
`default_nettype none

module cpuTb import cpuPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int addrWidth = 8;

    logic clk = 1'b0;
    logic rst;
    logic progWe;
    logic [addrWidth-1:0] progAddr;
    logic [dataWidth-1:0] progData;
    logic storeValid;
    logic [addrWidth-1:0] storeAddr;
    logic [dataWidth-1:0] storeData;

    logic [15:0] prog [$];
    logic [7:0] expAddr [$];
    logic [15:0] expData [$];
    // addresses written by immediate stores for the load tests
    logic [7:0] stored [$];
    logic [7:0] dataAddr = 8'h80;
    logic [31:0] rngState = 32'd7487;
    int totalStores = 0;
    int storesSeen = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    cpuTop #(.memAddrWidth(addrWidth)) dut0 (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] randByte();
        rngState = xorshift(rngState);
        return rngState[7:0];
    endfunction

    // source register index in 7:6 with random low bits
    function automatic logic [7:0] regField(input logic [1:0] s);
        logic [7:0] f;
        f = randByte();
        return {s, f[5:0]};
    endfunction

    function automatic logic [15:0] encode(input opcode_t op, input logic alt,
                                           input logic [1:0] d, input logic [7:0] field);
        return {op, alt, d, 1'b0, field};
    endfunction

    task automatic emit(input logic [15:0] word);
        prog.push_back(word);
    endtask

    task automatic storeImm(input logic [1:0] d);
        emit(encode(opStr, 1'b0, d, dataAddr));
        stored.push_back(dataAddr);
        dataAddr = dataAddr + 8'd1;
    endtask

    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH %s got 0x%04h expected 0x%04h", name, got, expected));
        end
    endtask

    task automatic buildProgram();
        opcode_t aluOps [7] = '{opAdd, opSub, opMul, opLsr, opAnd, opOr, opMvn};
        opcode_t condOps [3] = '{opBgt, opBlt, opBeq};
        logic [7:0] a;
        int p;
        // moves and both store forms with r1 pointing into the data area
        emit(encode(opNop, 1'b0, 2'd0, 8'h00));
        emit(encode(opMov, 1'b0, 2'd0, randByte()));
        storeImm(2'd0);
        emit(encode(opMov, 1'b0, 2'd1, 8'h80 | randByte()));
        emit(encode(opMov, 1'b1, 2'd2, regField(2'd0)));
        emit(encode(opStr, 1'b1, 2'd2, regField(2'd1)));
        // ALU ops chained on r0 in immediate then register form
        emit(encode(opMov, 1'b0, 2'd0, randByte()));
        for (int k = 0; k < 7; k++) begin
            emit(encode(opMov, 1'b0, 2'd3, randByte()));
            emit(encode(aluOps[k], 1'b0, 2'd0, randByte()));
            storeImm(2'd0);
            emit(encode(aluOps[k], 1'b1, 2'd0, regField(2'd3)));
            storeImm(2'd0);
        end
        // memory round trip
        emit(encode(opLdr, 1'b0, 2'd1, stored[randByte() % stored.size()]));
        storeImm(2'd1);
        emit(encode(opMov, 1'b0, 2'd2, stored[randByte() % stored.size()]));
        emit(encode(opLdr, 1'b1, 2'd3, regField(2'd2)));
        storeImm(2'd3);
        // cmp then a branch over the first of two stores
        for (int k = 0; k < 6; k++) begin
            a = randByte();
            if (k == 3 || k == 4) begin
                // r0 = 0x7fff so cmp against a negative r1 overflows
                emit(encode(opMvn, 1'b0, 2'd0, 8'h00));
                emit(encode(opLsr, 1'b0, 2'd0, 8'h01));
            end else begin
                emit(encode(opMov, 1'b0, 2'd0, a));
            end
            if (k >= 3) begin
                emit(encode(opMvn, 1'b0, 2'd1, randByte()));
            end else if (k == 2) begin
                emit(encode(opMov, 1'b0, 2'd1, a));
            end else begin
                emit(encode(opMov, 1'b0, 2'd1, randByte()));
            end
            p = prog.size();
            if (k == 5) begin
                emit(encode(opCmp, 1'b0, 2'd0, randByte()));
            end else begin
                emit(encode(opCmp, 1'b1, 2'd0, regField(2'd1)));
            end
            emit(encode(condOps[k % 3], 1'b0, 2'd0, 8'(p + 3)));
            storeImm(2'd0);
            storeImm(2'd1);
        end
        // park on a branch to self
        p = prog.size();
        emit(encode(opB, 1'b0, 2'd0, 8'(p)));
    endtask

    // instruction-level model that returns the executed instruction count
    function automatic int runModel();
        logic [15:0] mem [256];
        logic [15:0] r [4];
        logic [15:0] pc, w, a, b, res;
        logic fn, fz, fv, alt, done;
        logic [1:0] d, s;
        logic [7:0] imm;
        opcode_t op;
        int steps, sa, sb, t;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (i < prog.size()) ? prog[i] : 16'h0000;
        end
        for (int i = 0; i < 4; i++) begin
            r[i] = 16'h0000;
        end
        {fn, fz, fv} = 3'b000;
        pc = 16'h0000;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4096) begin
            w = mem[pc[7:0]];
            op = opcode_t'(w[15:12]);
            alt = w[11];
            d = w[10:9];
            s = w[7:6];
            imm = w[7:0];
            steps++;
            done = (op == opB) && (imm == pc[7:0]);
            pc = pc + 16'd1;
            a = r[d];
            b = alt ? r[s] : {8'h00, imm};
            case (op)
                opNop: ;
                opMov: r[d] = b;
                opLdr: r[d] = mem[b[7:0]];
                opStr: begin
                    mem[b[7:0]] = a;
                    expAddr.push_back(b[7:0]);
                    expData.push_back(a);
                end
                opB:   pc = {8'h00, imm};
                opBgt: if (!fz && fn == fv) pc = {8'h00, imm};
                opBlt: if (fn != fv) pc = {8'h00, imm};
                opBeq: if (fz) pc = {8'h00, imm};
                default: begin
                    fv = 1'b0;
                    sa = int'($signed(a));
                    sb = int'($signed(b));
                    case (op)
                        opAdd: begin
                            t = int'(a) + int'(b);
                            res = 16'(t);
                            t = sa + sb;
                            fv = t > 32767 || t < -32768;
                        end
                        opMul: res = a * b;
                        opLsr: res = a >> b[3:0];
                        opAnd: res = a & b;
                        opOr:  res = a | b;
                        opMvn: res = ~b;
                        // sub and cmp
                        default: begin
                            res = a - b;
                            t = sa - sb;
                            fv = t > 32767 || t < -32768;
                        end
                    endcase
                    fn = res[15];
                    fz = (res == 16'h0000);
                    if (op != opCmp) r[d] = res;
                end
            endcase
        end
        return steps;
    endfunction

    initial begin : mainFlow
        int modelSteps;
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        buildProgram();
        modelSteps = runModel();
        totalStores = expAddr.size();
        cycleLimit = 7 * modelSteps + 50;
        // reset stays high through the load and eight more cycles
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #1;
            progWe = 1'b1;
            progAddr = addrWidth'(i);
            progData = prog[i];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (storesSeen == totalStores);
        // a few idle cycles to catch stray stores
        repeat (20) @(posedge clk);
        if (storesSeen == totalStores && expAddr.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            failRun("the number of stores differs from the model");
        end
    end

    // outputs are settled by the falling edge
    initial begin : compareStores
        logic [7:0] addrExp;
        logic [15:0] dataExp;
        forever begin
            @(negedge clk);
            if (storeValid === 1'b1) begin
                if (rst) begin
                    failRun("a store appeared while reset was asserted");
                end else if (expAddr.size() == 0) begin
                    failRun("the DUT made a store that the model does not expect");
                end else begin
                    addrExp = expAddr.pop_front();
                    dataExp = expData.pop_front();
                    checkValue("storeAddr", {8'h00, storeAddr}, {8'h00, addrExp});
                    checkValue("storeData", storeData, dataExp);
                    storesSeen++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst === 1'b0) begin
            cycleCount = cycleCount + 1;
            if (cycleCount > cycleLimit) begin
                failRun("timeout: the expected stores did not all appear in time");
            end
        end
    end

endmodule

`default_nettype wire

/* tests/cpuTop_sva.sv */
`default_nettype none

module cpuTopChecks import cpuPkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [stateCount-1:0] cpuState,
    input logic                  storeValid,
    input logic                  counterClr
);

    timeunit 1ns;
    timeprecision 1ps;

    stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(cpuState))
        else $error("state vector is not one-hot");

    // memory writes must wait for reset release
    noStoreInReset: assert property (@(posedge clk) rst |-> !storeValid)
        else $error("store strobe high during reset");

    clearToFetch: assert property (@(posedge clk) disable iff (rst) counterClr |=> cpuState[0])
        else $error("counter clear did not return to fetch1");

endmodule

bind cpuTop cpuTopChecks checks0 (
    .clk(clk),
    .rst(rst),
    .cpuState(cpuState),
    .storeValid(storeValid),
    .counterClr(counterClr)
);

`default_nettype wire

/* vlog.f */
source/cpuPkg.sv
source/sequenceCounter.sv
source/controlLogic.sv
source/aluUnit.sv
source/dataPath.sv
source/mainMemory.sv
source/cpuTop.sv
tests/cpuTop_sva.sv
tests/cpuTb.sv
